// ==== hdl/la_decode_pkg.sv ====
`default_nettype none

package la_decode_pkg;

  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int alu_op_w    = 12;
  localparam int mem_width_w = 4;
  localparam int br_kind_w   = 3;

  // bit positions in the one-hot alu op
  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_and  = 4;
  localparam int alu_nor  = 5;
  localparam int alu_or   = 6;
  localparam int alu_xor  = 7;
  localparam int alu_sll  = 8;
  localparam int alu_srl  = 9;
  localparam int alu_sra  = 10;
  localparam int alu_lui  = 11;

  localparam logic [br_kind_w-1:0] br_none = 3'd0;
  localparam logic [br_kind_w-1:0] br_eq   = 3'd1;
  localparam logic [br_kind_w-1:0] br_ne   = 3'd2;
  localparam logic [br_kind_w-1:0] br_lt   = 3'd3;
  localparam logic [br_kind_w-1:0] br_ge   = 3'd4;
  localparam logic [br_kind_w-1:0] br_ltu  = 3'd5;
  localparam logic [br_kind_w-1:0] br_geu  = 3'd6;
  localparam logic [br_kind_w-1:0] br_jump = 3'd7;  // b, bl, jirl

  // inst[31:26]
  localparam logic [5:0] op6_alu    = 6'h00;
  localparam logic [5:0] op6_lu12i  = 6'h05;
  localparam logic [5:0] op6_pcaddu = 6'h07;
  localparam logic [5:0] op6_mem    = 6'h0a;
  localparam logic [5:0] op6_jirl   = 6'h13;
  localparam logic [5:0] op6_b      = 6'h14;
  localparam logic [5:0] op6_bl     = 6'h15;
  localparam logic [5:0] op6_beq    = 6'h16;
  localparam logic [5:0] op6_bne    = 6'h17;
  localparam logic [5:0] op6_blt    = 6'h18;
  localparam logic [5:0] op6_bge    = 6'h19;
  localparam logic [5:0] op6_bltu   = 6'h1a;
  localparam logic [5:0] op6_bgeu   = 6'h1b;

  // inst[25:22], alu group
  localparam logic [3:0] op4_3r      = 4'h0;
  localparam logic [3:0] op4_shift_i = 4'h1;
  localparam logic [3:0] op4_slti    = 4'h8;
  localparam logic [3:0] op4_sltui   = 4'h9;
  localparam logic [3:0] op4_addi    = 4'ha;
  localparam logic [3:0] op4_andi    = 4'hd;
  localparam logic [3:0] op4_ori     = 4'he;
  localparam logic [3:0] op4_xori    = 4'hf;

  // inst[25:22], memory group
  localparam logic [3:0] op4_ld_b  = 4'h0;
  localparam logic [3:0] op4_ld_h  = 4'h1;
  localparam logic [3:0] op4_ld_w  = 4'h2;
  localparam logic [3:0] op4_st_b  = 4'h4;
  localparam logic [3:0] op4_st_h  = 4'h5;
  localparam logic [3:0] op4_st_w  = 4'h6;
  localparam logic [3:0] op4_ld_bu = 4'h8;
  localparam logic [3:0] op4_ld_hu = 4'h9;

  // inst[21:20]
  localparam logic [1:0] op2_3r      = 2'h1;
  localparam logic [1:0] op2_shift_i = 2'h0;

  // inst[19:15]
  localparam logic [4:0] op5_add  = 5'h00;
  localparam logic [4:0] op5_sub  = 5'h02;
  localparam logic [4:0] op5_slt  = 5'h04;
  localparam logic [4:0] op5_sltu = 5'h05;
  localparam logic [4:0] op5_nor  = 5'h08;
  localparam logic [4:0] op5_and  = 5'h09;
  localparam logic [4:0] op5_or   = 5'h0a;
  localparam logic [4:0] op5_xor  = 5'h0b;
  localparam logic [4:0] op5_sll  = 5'h0e;
  localparam logic [4:0] op5_srl  = 5'h0f;
  localparam logic [4:0] op5_sra  = 5'h10;
  localparam logic [4:0] op5_slli = 5'h01;
  localparam logic [4:0] op5_srli = 5'h09;
  localparam logic [4:0] op5_srai = 5'h11;

  typedef union packed {
    struct packed {
      logic [16:0]           opcode;
      logic [reg_addr_w-1:0] rk;
      logic [reg_addr_w-1:0] rj;
      logic [reg_addr_w-1:0] rd;
    } fmt_3r;
    struct packed {
      logic [9:0]            opcode;
      logic [11:0]           i12;
      logic [reg_addr_w-1:0] rj;
      logic [reg_addr_w-1:0] rd;
    } fmt_2ri12;
    struct packed {
      logic [5:0]            opcode;
      logic [15:0]           i16;
      logic [reg_addr_w-1:0] rj;
      logic [reg_addr_w-1:0] rd;
    } fmt_2ri16;
  } la_inst_t;

endpackage

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import la_decode_pkg::*;
(
  input  la_inst_t               inst,
  input  logic [xlen-1:0]        pc,
  input  logic [xlen-1:0]        rj_data,
  input  logic [xlen-1:0]        rkd_data,
  output logic [reg_addr_w-1:0]  raddr_rj,
  output logic [reg_addr_w-1:0]  raddr_rkd,
  output logic [alu_op_w-1:0]    alu_op,
  output logic [mem_width_w-1:0] mem_width,
  output logic                   mem_we,
  output logic                   res_from_mem,
  output logic                   gr_we,
  output logic [reg_addr_w-1:0]  dest,
  output logic [xlen-1:0]        imm,
  output logic                   src1_is_pc,
  output logic                   src2_is_imm,
  output logic                   src2_is_4,
  output logic [br_kind_w-1:0]   br_kind,
  output logic                   use_rj_target,
  output logic                   use_rj,
  output logic                   use_rkd,
  output logic                   is_branch,
  output logic                   is_mem,
  output logic [xlen-1:0]        rj_value,
  output logic [xlen-1:0]        rkd_value,
  output logic [xlen-1:0]        inst_pc
);

  logic [5:0]  op6;
  logic [3:0]  op4;
  logic [11:0] op_hi;
  logic [4:0]  op5;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;
  logic is_3r, is_shi, is_alu, is_mem_grp;
  logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
  logic inst_sll, inst_srl, inst_sra, inst_slli, inst_srli, inst_srai;
  logic inst_addi, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
  logic inst_lu12i, inst_pcaddu;
  logic ld_b, ld_h, ld_w, ld_bu, ld_hu, st_b, st_h, st_w, is_ld, is_st;
  logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  logic cond_br, need_ui5, need_si12, need_si16, need_si20, need_si26;

  // one word, three views
  assign op6   = inst.fmt_2ri16.opcode;
  assign op4   = inst.fmt_2ri12.opcode[3:0];
  assign op_hi = inst.fmt_3r.opcode[16:5];
  assign op5   = inst.fmt_3r.opcode[4:0];
  assign i12   = inst.fmt_2ri12.i12;
  assign i16   = inst.fmt_2ri16.i16;
  assign i20   = {inst.fmt_2ri16.i16[14:0], inst.fmt_2ri16.rj};
  assign i26   = {inst.fmt_2ri16.rj, inst.fmt_2ri16.rd, inst.fmt_2ri16.i16};

  assign is_3r      = op_hi == {op6_alu, op4_3r, op2_3r};
  assign is_shi     = op_hi == {op6_alu, op4_shift_i, op2_shift_i};
  assign is_alu     = op6 == op6_alu;
  assign is_mem_grp = op6 == op6_mem;

  assign inst_add  = is_3r & (op5 == op5_add);
  assign inst_sub  = is_3r & (op5 == op5_sub);
  assign inst_slt  = is_3r & (op5 == op5_slt);
  assign inst_sltu = is_3r & (op5 == op5_sltu);
  assign inst_nor  = is_3r & (op5 == op5_nor);
  assign inst_and  = is_3r & (op5 == op5_and);
  assign inst_or   = is_3r & (op5 == op5_or);
  assign inst_xor  = is_3r & (op5 == op5_xor);
  assign inst_sll  = is_3r & (op5 == op5_sll);
  assign inst_srl  = is_3r & (op5 == op5_srl);
  assign inst_sra  = is_3r & (op5 == op5_sra);
  assign inst_slli = is_shi & (op5 == op5_slli);
  assign inst_srli = is_shi & (op5 == op5_srli);
  assign inst_srai = is_shi & (op5 == op5_srai);

  assign inst_addi  = is_alu & (op4 == op4_addi);
  assign inst_slti  = is_alu & (op4 == op4_slti);
  assign inst_sltui = is_alu & (op4 == op4_sltui);
  assign inst_andi  = is_alu & (op4 == op4_andi);
  assign inst_ori   = is_alu & (op4 == op4_ori);
  assign inst_xori  = is_alu & (op4 == op4_xori);

  assign inst_lu12i  = (op6 == op6_lu12i) & ~i16[15];  // inst[25] must be 0
  assign inst_pcaddu = (op6 == op6_pcaddu) & ~i16[15];

  assign ld_b  = is_mem_grp & (op4 == op4_ld_b);
  assign ld_h  = is_mem_grp & (op4 == op4_ld_h);
  assign ld_w  = is_mem_grp & (op4 == op4_ld_w);
  assign ld_bu = is_mem_grp & (op4 == op4_ld_bu);
  assign ld_hu = is_mem_grp & (op4 == op4_ld_hu);
  assign st_b  = is_mem_grp & (op4 == op4_st_b);
  assign st_h  = is_mem_grp & (op4 == op4_st_h);
  assign st_w  = is_mem_grp & (op4 == op4_st_w);
  assign is_ld = ld_b | ld_h | ld_w | ld_bu | ld_hu;
  assign is_st = st_b | st_h | st_w;

  assign inst_jirl = op6 == op6_jirl;
  assign inst_b    = op6 == op6_b;
  assign inst_bl   = op6 == op6_bl;
  assign inst_beq  = op6 == op6_beq;
  assign inst_bne  = op6 == op6_bne;
  assign inst_blt  = op6 == op6_blt;
  assign inst_bge  = op6 == op6_bge;
  assign inst_bltu = op6 == op6_bltu;
  assign inst_bgeu = op6 == op6_bgeu;
  assign cond_br   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

  assign alu_op[alu_add]  = inst_add | inst_addi | is_ld | is_st | inst_jirl | inst_bl |
                            inst_pcaddu;
  assign alu_op[alu_sub]  = inst_sub | inst_beq | inst_bne;
  assign alu_op[alu_slt]  = inst_slt | inst_slti | inst_blt | inst_bge;
  assign alu_op[alu_sltu] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
  assign alu_op[alu_and]  = inst_and | inst_andi;
  assign alu_op[alu_nor]  = inst_nor;
  assign alu_op[alu_or]   = inst_or | inst_ori;
  assign alu_op[alu_xor]  = inst_xor | inst_xori;
  assign alu_op[alu_sll]  = inst_sll | inst_slli;
  assign alu_op[alu_srl]  = inst_srl | inst_srli;
  assign alu_op[alu_sra]  = inst_sra | inst_srai;
  assign alu_op[alu_lui]  = inst_lu12i;

  assign mem_width = (ld_w | st_w)         ? 4'hf :
                     (ld_h | ld_hu | st_h) ? 4'h3 :
                     (ld_b | ld_bu | st_b) ? 4'h1 : 4'h0;
  assign mem_we       = is_st;
  assign res_from_mem = is_ld;
  assign is_mem       = is_ld | is_st;

  assign need_ui5  = inst_slli | inst_srli | inst_srai;
  assign need_si12 = inst_addi | inst_slti | inst_sltui | is_ld | is_st;
  assign need_si16 = cond_br | inst_jirl;
  assign need_si20 = inst_lu12i | inst_pcaddu;
  assign need_si26 = inst_b | inst_bl;

  assign imm = need_si20 ? {i20, 12'b0} :
               need_ui5  ? {27'b0, inst.fmt_3r.rk} :
               need_si26 ? {{6{i26[25]}}, i26} :
               need_si16 ? {{16{i16[15]}}, i16} :
               need_si12 ? {{20{i12[11]}}, i12} :
                           {20'b0, i12};  // logic immediates zero-extend

  assign src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu;
  assign src2_is_4   = inst_jirl | inst_bl;
  assign src2_is_imm = need_si12 | need_ui5 | need_si20 | inst_andi | inst_ori | inst_xori;

  always_comb begin
    br_kind = br_none;
    if (inst_beq) br_kind = br_eq;
    if (inst_bne) br_kind = br_ne;
    if (inst_blt) br_kind = br_lt;
    if (inst_bge) br_kind = br_ge;
    if (inst_bltu) br_kind = br_ltu;
    if (inst_bgeu) br_kind = br_geu;
    if (inst_b | inst_bl | inst_jirl) br_kind = br_jump;
  end

  assign use_rj_target = inst_jirl;
  assign is_branch     = cond_br | inst_b | inst_bl | inst_jirl;
  assign gr_we         = ~(is_st | cond_br | inst_b);
  assign dest          = inst_bl ? 5'd1 : inst.fmt_3r.rd;  // bl links to r1

  // branches and stores compare or store rd
  assign raddr_rj  = inst.fmt_3r.rj;
  assign raddr_rkd = (cond_br | is_st) ? inst.fmt_3r.rd : inst.fmt_3r.rk;
  assign use_rj    = ~(need_si20 | need_si26);
  assign use_rkd   = is_3r | cond_br | is_st;

  assign rj_value  = rj_data;
  assign rkd_value = rkd_data;
  assign inst_pc   = pc;

endmodule

`default_nettype wire

// ==== hdl/pair_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_check
  import la_decode_pkg::*;
(
  input  logic                  gr_we0,
  input  logic [reg_addr_w-1:0] dest0,
  input  logic                  is_branch0,
  input  logic                  is_mem0,
  input  logic                  is_mem1,
  input  logic                  use_rj1,
  input  logic                  use_rkd1,
  input  logic [reg_addr_w-1:0] raddr_rj1,
  input  logic [reg_addr_w-1:0] raddr_rkd1,
  output logic                  pair_ok
);

  logic writes0;
  logic raw;

  // writes to r0 are discarded, no dependence
  assign writes0 = gr_we0 & (|dest0);

  assign raw = writes0 & ((use_rj1 & (raddr_rj1 == dest0)) |
                          (use_rkd1 & (raddr_rkd1 == dest0)));

  // one memory port, branch resolves alone
  assign pair_ok = ~is_branch0 & ~is_mem0 & ~is_mem1 & ~raw;

endmodule

`default_nettype wire

// ==== hdl/issue_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_reg
  import la_decode_pkg::*;
(
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              ready,
  input  logic                              flush,
  input  logic [1:0]                        next_valid,
  input  logic [1:0][alu_op_w-1:0]          alu_op,
  input  logic [1:0][mem_width_w-1:0]       mem_width,
  input  logic [1:0]                        mem_we,
  input  logic [1:0]                        res_from_mem,
  input  logic [1:0]                        gr_we,
  input  logic [1:0][reg_addr_w-1:0]        dest,
  input  logic [1:0][xlen-1:0]              imm,
  input  logic [1:0]                        src1_is_pc,
  input  logic [1:0]                        src2_is_imm,
  input  logic [1:0]                        src2_is_4,
  input  logic [1:0][br_kind_w-1:0]         br_kind,
  input  logic [1:0]                        use_rj_target,
  input  logic [1:0][xlen-1:0]              rj_value,
  input  logic [1:0][xlen-1:0]              rkd_value,
  input  logic [1:0][xlen-1:0]              pc,
  input  logic [1:0]                        pc_is_jump,
  output logic [1:0]                        ex_valid,
  output logic [1:0][alu_op_w-1:0]          ex_alu_op,
  output logic [1:0][mem_width_w-1:0]       ex_mem_width,
  output logic [1:0]                        ex_mem_we,
  output logic [1:0]                        ex_res_from_mem,
  output logic [1:0]                        ex_gr_we,
  output logic [1:0][reg_addr_w-1:0]        ex_dest,
  output logic [1:0][xlen-1:0]              ex_imm,
  output logic [1:0]                        ex_src1_is_pc,
  output logic [1:0]                        ex_src2_is_imm,
  output logic [1:0]                        ex_src2_is_4,
  output logic [1:0][br_kind_w-1:0]         ex_br_kind,
  output logic [1:0]                        ex_use_rj_target,
  output logic [1:0][xlen-1:0]              ex_rj_value,
  output logic [1:0][xlen-1:0]              ex_rkd_value,
  output logic [1:0][xlen-1:0]              ex_pc,
  output logic [1:0]                        ex_pc_is_jump
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= '0;
    end else if (flush) begin  // wins over a stall
      ex_valid <= '0;
    end else if (ready) begin
      ex_valid <= next_valid;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_alu_op        <= '0;
      ex_mem_width     <= '0;
      ex_mem_we        <= '0;
      ex_res_from_mem  <= '0;
      ex_gr_we         <= '0;
      ex_dest          <= '0;
      ex_imm           <= '0;
      ex_src1_is_pc    <= '0;
      ex_src2_is_imm   <= '0;
      ex_src2_is_4     <= '0;
      ex_br_kind       <= '0;
      ex_use_rj_target <= '0;
      ex_rj_value      <= '0;
      ex_rkd_value     <= '0;
      ex_pc            <= '0;
      ex_pc_is_jump    <= '0;
    end else if (ready) begin
      ex_alu_op        <= alu_op;
      ex_mem_width     <= mem_width;
      ex_mem_we        <= mem_we;
      ex_res_from_mem  <= res_from_mem;
      ex_gr_we         <= gr_we;
      ex_dest          <= dest;
      ex_imm           <= imm;
      ex_src1_is_pc    <= src1_is_pc;
      ex_src2_is_imm   <= src2_is_imm;
      ex_src2_is_4     <= src2_is_4;
      ex_br_kind       <= br_kind;
      ex_use_rj_target <= use_rj_target;
      ex_rj_value      <= rj_value;
      ex_rkd_value     <= rkd_value;
      ex_pc            <= pc;
      ex_pc_is_jump    <= pc_is_jump;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import la_decode_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        fetch_valid,
  input  logic [1:0]                  slot_valid,
  input  logic [1:0][xlen-1:0]        slot_pc,
  input  logic [1:0][xlen-1:0]        slot_inst,
  input  logic [1:0]                  slot_pc_is_jump,
  output logic [1:0]                  pop,
  output logic [3:0][reg_addr_w-1:0]  rf_raddr,
  input  logic [3:0][xlen-1:0]        rf_rdata,
  input  logic                        issue_ready,
  input  logic                        flush,
  output logic [1:0]                  ex_valid,
  output logic [1:0][alu_op_w-1:0]    ex_alu_op,
  output logic [1:0][mem_width_w-1:0] ex_mem_width,
  output logic [1:0]                  ex_mem_we,
  output logic [1:0]                  ex_res_from_mem,
  output logic [1:0]                  ex_gr_we,
  output logic [1:0][reg_addr_w-1:0]  ex_dest,
  output logic [1:0][xlen-1:0]        ex_imm,
  output logic [1:0]                  ex_src1_is_pc,
  output logic [1:0]                  ex_src2_is_imm,
  output logic [1:0]                  ex_src2_is_4,
  output logic [1:0][br_kind_w-1:0]   ex_br_kind,
  output logic [1:0]                  ex_use_rj_target,
  output logic [1:0][xlen-1:0]        ex_rj_value,
  output logic [1:0][xlen-1:0]        ex_rkd_value,
  output logic [1:0][xlen-1:0]        ex_pc,
  output logic [1:0]                  ex_pc_is_jump
);

  logic [1:0][alu_op_w-1:0]    alu_op;
  logic [1:0][mem_width_w-1:0] mem_width;
  logic [1:0][reg_addr_w-1:0]  dest;
  logic [1:0][xlen-1:0]        imm, rj_value, rkd_value, pc;
  logic [1:0][br_kind_w-1:0]   br_kind;
  logic [1:0] mem_we, res_from_mem, gr_we, src1_is_pc, src2_is_imm, src2_is_4;
  logic [1:0] use_rj_target, use_rj, use_rkd, is_branch, is_mem;
  logic [1:0] next_valid;
  logic       pair_ok;

  inst_decoder dec0_i (
    .inst(slot_inst[0]), .pc(slot_pc[0]),
    .rj_data(rf_rdata[0]), .rkd_data(rf_rdata[1]),
    .raddr_rj(rf_raddr[0]), .raddr_rkd(rf_raddr[1]),
    .alu_op(alu_op[0]), .mem_width(mem_width[0]), .mem_we(mem_we[0]),
    .res_from_mem(res_from_mem[0]), .gr_we(gr_we[0]), .dest(dest[0]), .imm(imm[0]),
    .src1_is_pc(src1_is_pc[0]), .src2_is_imm(src2_is_imm[0]), .src2_is_4(src2_is_4[0]),
    .br_kind(br_kind[0]), .use_rj_target(use_rj_target[0]),
    .use_rj(use_rj[0]), .use_rkd(use_rkd[0]), .is_branch(is_branch[0]), .is_mem(is_mem[0]),
    .rj_value(rj_value[0]), .rkd_value(rkd_value[0]), .inst_pc(pc[0])
  );

  inst_decoder dec1_i (
    .inst(slot_inst[1]), .pc(slot_pc[1]),
    .rj_data(rf_rdata[2]), .rkd_data(rf_rdata[3]),
    .raddr_rj(rf_raddr[2]), .raddr_rkd(rf_raddr[3]),
    .alu_op(alu_op[1]), .mem_width(mem_width[1]), .mem_we(mem_we[1]),
    .res_from_mem(res_from_mem[1]), .gr_we(gr_we[1]), .dest(dest[1]), .imm(imm[1]),
    .src1_is_pc(src1_is_pc[1]), .src2_is_imm(src2_is_imm[1]), .src2_is_4(src2_is_4[1]),
    .br_kind(br_kind[1]), .use_rj_target(use_rj_target[1]),
    .use_rj(use_rj[1]), .use_rkd(use_rkd[1]), .is_branch(is_branch[1]), .is_mem(is_mem[1]),
    .rj_value(rj_value[1]), .rkd_value(rkd_value[1]), .inst_pc(pc[1])
  );

  pair_check pair_i (
    .gr_we0(gr_we[0]),
    .dest0(dest[0]),
    .is_branch0(is_branch[0]),
    .is_mem0(is_mem[0]),
    .is_mem1(is_mem[1]),
    .use_rj1(use_rj[1]),
    .use_rkd1(use_rkd[1]),
    .raddr_rj1(rf_raddr[2]),
    .raddr_rkd1(rf_raddr[3]),
    .pair_ok(pair_ok)
  );

  // slot 1 never issues ahead of slot 0
  assign next_valid[0] = slot_valid[0] & fetch_valid;
  assign next_valid[1] = next_valid[0] & slot_valid[1] & pair_ok;
  assign pop           = next_valid & {2{issue_ready}};

  issue_reg ireg_i (
    .ready(issue_ready),
    .pc_is_jump(slot_pc_is_jump),
    .*
  );

endmodule

`default_nettype wire

// ==== bench/decode_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_checker
  import la_decode_pkg::*;
(
  input logic                     clk,
  input logic                     arst_n,
  input logic                     issue_ready,
  input logic                     flush,
  input logic [1:0]               pop,
  input logic [1:0]               ex_valid,
  input logic [1:0][alu_op_w-1:0] ex_alu_op,
  input logic [1:0][xlen-1:0]     ex_imm,
  input logic [1:0][xlen-1:0]     ex_rj_value,
  input logic [1:0][xlen-1:0]     ex_pc
);

  stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (!issue_ready && !flush) |=> ($stable(ex_valid) && $stable(ex_alu_op) &&
                                  $stable(ex_imm) && $stable(ex_rj_value) && $stable(ex_pc)))
    else $error("issue register changed while stalled");

  stall_no_pop: assert property (@(posedge clk) disable iff (!arst_n)
    !issue_ready |-> (pop == 2'b00))
    else $error("pop asserted while execute not ready");

  flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> (ex_valid == 2'b00))
    else $error("flush did not clear the issue register");

  // slot 1 never leaves fetch alone
  pop_order: assert property (@(posedge clk) disable iff (!arst_n)
    pop[1] |-> pop[0])
    else $error("slot 1 popped without slot 0");

endmodule

bind decode_stage decode_stage_checker chk_i (
  .clk(clk),
  .arst_n(arst_n),
  .issue_ready(issue_ready),
  .flush(flush),
  .pop(pop),
  .ex_valid(ex_valid),
  .ex_alu_op(ex_alu_op),
  .ex_imm(ex_imm),
  .ex_rj_value(ex_rj_value),
  .ex_pc(ex_pc)
);

`default_nettype wire

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb
  import la_decode_pkg::*;
();

  localparam int n_vectors = 40;
  localparam int reset_ns  = 12;
  localparam logic [xlen-1:0] nop = 32'h0;

  logic clk, arst_n, fetch_valid, issue_ready, flush;
  logic [1:0] slot_valid, slot_pc_is_jump, pop;
  logic [1:0][xlen-1:0] slot_pc, slot_inst;
  logic [3:0][reg_addr_w-1:0] rf_raddr;
  logic [3:0][xlen-1:0] rf_rdata;
  logic [1:0] ex_valid, ex_mem_we, ex_res_from_mem, ex_gr_we, ex_src1_is_pc;
  logic [1:0] ex_src2_is_imm, ex_src2_is_4, ex_use_rj_target, ex_pc_is_jump;
  logic [1:0][alu_op_w-1:0] ex_alu_op;
  logic [1:0][mem_width_w-1:0] ex_mem_width;
  logic [1:0][reg_addr_w-1:0] ex_dest;
  logic [1:0][xlen-1:0] ex_imm, ex_rj_value, ex_rkd_value, ex_pc;
  logic [1:0][br_kind_w-1:0] ex_br_kind;
  logic [reg_addr_w-1:0] raddr1_seen, rd0, rj1, rk1;
  logic [xlen-1:0] pc_next, pc_sent, held_imm;

  decode_stage dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [xlen-1:0] rf_val(input logic [reg_addr_w-1:0] a);
    return {4{{3'b000, a}}};  // a in every byte
  endfunction

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rf_rdata[p] = rf_val(rf_raddr[p]);
    end
  end

  function automatic logic [xlen-1:0] r3(input logic [4:0] op5, rk, rj, rd);
    return {op6_alu, op4_3r, op2_3r, op5, rk, rj, rd};
  endfunction

  function automatic logic [xlen-1:0] shi(input logic [4:0] op5, ui5, rj, rd);
    return {op6_alu, op4_shift_i, op2_shift_i, op5, ui5, rj, rd};
  endfunction

  function automatic logic [xlen-1:0] ri12(input logic [5:0] op6, input logic [3:0] op4,
                                           input logic [11:0] i12, input logic [4:0] rj, rd);
    return {op6, op4, i12, rj, rd};
  endfunction

  function automatic logic [xlen-1:0] ri16(input logic [5:0] op6, input logic [15:0] i16,
                                           input logic [4:0] rj, rd);
    return {op6, i16, rj, rd};
  endfunction

  function automatic logic [xlen-1:0] ri20(input logic [5:0] op6, input logic [19:0] i20,
                                           input logic [4:0] rd);
    return {op6, 1'b0, i20, rd};
  endfunction

  // offs[15:0] sits above offs[25:16]
  function automatic logic [xlen-1:0] i26(input logic [5:0] op6, input logic [25:0] offs);
    return {op6, offs[15:0], offs[25:16]};
  endfunction

  function automatic logic [alu_op_w-1:0] onehot(input int pos);
    logic [alu_op_w-1:0] v;
    v = '0;
    v[pos] = 1'b1;
    return v;
  endfunction

  task automatic expect_eq(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] want);
    assert (got === want) else begin
      $display("FAILED %s got %h expected %h", name, got, want);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // called on a falling edge, returns on the next one
  task automatic step(input logic [xlen-1:0] i0, i1, input logic [1:0] valid, exp_pop);
    slot_inst[0] = i0;
    slot_inst[1] = i1;
    slot_valid = valid;
    slot_pc[0] = pc_next;
    slot_pc[1] = pc_next + 4;
    slot_pc_is_jump = pc_next[4:3];  // varies per step
    fetch_valid = 1'b1;
    issue_ready = 1'b1;
    flush = 1'b0;
    pc_sent = pc_next;
    pc_next = pc_next + 8;
    #1;
    expect_eq("pop", 32'(pop), 32'(exp_pop));
    raddr1_seen = rf_raddr[1];
    @(negedge clk);
    expect_eq("ex_valid", 32'(ex_valid), 32'(exp_pop));
    expect_eq("ex_pc_is_jump", 32'(ex_pc_is_jump), 32'(pc_sent[4:3]));
  endtask

  task automatic check_alu(input int op, input logic [xlen-1:0] imm);
    expect_eq("ex_alu_op[0]", 32'(ex_alu_op[0]), 32'(onehot(op)));
    expect_eq("ex_imm[0]", ex_imm[0], imm);
    expect_eq("ex_src2_is_imm[0]", 32'(ex_src2_is_imm[0]), 32'h1);
    expect_eq("ex_pc[0]", ex_pc[0], pc_sent);
  endtask

  initial begin
    #(reset_ns + n_vectors * 40);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(56707));
    arst_n = 1'b0;
    fetch_valid = 1'b0;
    issue_ready = 1'b0;
    flush = 1'b0;
    slot_valid = '0;
    slot_pc = '0;
    slot_inst = '0;
    slot_pc_is_jump = '0;
    pc_next = 32'h1c00_0000;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    slot_valid = 2'b11;  // slots waiting, execute not ready
    fetch_valid = 1'b1;
    #1;
    expect_eq("pop", 32'(pop), 32'h0);
    @(negedge clk);
    expect_eq("ex_valid", 32'(ex_valid), 32'h0);

    step(ri12(op6_alu, op4_addi, 12'hffc, 5'd3, 5'd5), nop, 2'b01, 2'b01);
    check_alu(alu_add, 32'hffff_fffc);
    expect_eq("ex_rj_value[0]", ex_rj_value[0], rf_val(5'd3));
    expect_eq("ex_dest[0]", 32'(ex_dest[0]), 32'd5);
    step(ri12(op6_alu, op4_andi, 12'h800, 5'd7, 5'd6), nop, 2'b01, 2'b01);
    check_alu(alu_and, 32'h0000_0800);  // logic ops zero-extend
    step(shi(op5_slli, 5'd13, 5'd9, 5'd8), nop, 2'b01, 2'b01);
    check_alu(alu_sll, 32'd13);
    expect_eq("ex_rj_value[0]", ex_rj_value[0], rf_val(5'd9));
    step(ri20(op6_lu12i, 20'h80001, 5'd10), nop, 2'b01, 2'b01);
    check_alu(alu_lui, 32'h8000_1000);
    step(ri20(op6_pcaddu, 20'h12345, 5'd11), nop, 2'b01, 2'b01);
    check_alu(alu_add, 32'h1234_5000);
    expect_eq("ex_src1_is_pc[0]", 32'(ex_src1_is_pc[0]), 32'h1);

    step(ri12(op6_mem, op4_st_w, 12'h008, 5'd13, 5'd12), nop, 2'b01, 2'b01);
    expect_eq("rf_raddr[1]", 32'(raddr1_seen), 32'd12);
    expect_eq("ex_gr_we[0]", 32'(ex_gr_we[0]), 32'h0);
    expect_eq("ex_mem_width[0]", 32'(ex_mem_width[0]), 32'hf);
    expect_eq("ex_mem_we[0]", 32'(ex_mem_we[0]), 32'h1);
    expect_eq("ex_rkd_value[0]", ex_rkd_value[0], rf_val(5'd12));
    step(ri16(op6_beq, 16'h0010, 5'd14, 5'd15), nop, 2'b01, 2'b01);
    expect_eq("rf_raddr[1]", 32'(raddr1_seen), 32'd15);
    expect_eq("ex_gr_we[0]", 32'(ex_gr_we[0]), 32'h0);
    expect_eq("ex_br_kind[0]", 32'(ex_br_kind[0]), 32'(br_eq));
    step(ri12(op6_mem, op4_ld_h, 12'hffe, 5'd17, 5'd16), nop, 2'b01, 2'b01);
    expect_eq("ex_res_from_mem[0]", 32'(ex_res_from_mem[0]), 32'h1);
    expect_eq("ex_mem_width[0]", 32'(ex_mem_width[0]), 32'h3);
    expect_eq("ex_mem_we[0]", 32'(ex_mem_we[0]), 32'h0);

    step(i26(op6_bl, 26'h200_0123), nop, 2'b01, 2'b01);
    expect_eq("ex_dest[0]", 32'(ex_dest[0]), 32'd1);
    expect_eq("ex_src2_is_4[0]", 32'(ex_src2_is_4[0]), 32'h1);
    expect_eq("ex_src1_is_pc[0]", 32'(ex_src1_is_pc[0]), 32'h1);
    expect_eq("ex_imm[0]", ex_imm[0], 32'hfe00_0123);
    step(ri16(op6_jirl, 16'h0004, 5'd1, 5'd0), nop, 2'b01, 2'b01);
    expect_eq("ex_use_rj_target[0]", 32'(ex_use_rj_target[0]), 32'h1);

    for (int n = 0; n < 8; n++) begin
      rd0 = 5'(1 + $urandom % 31);
      rj1 = 5'(rd0 + 1 + $urandom % 31);  // never rd0
      rk1 = 5'(rd0 + 1 + $urandom % 31);
      step(r3(op5_add, 5'(n), 5'(n + 1), rd0), r3(op5_xor, rk1, rj1, 5'(n + 2)), 2'b11, 2'b11);
      expect_eq("ex_alu_op[1]", 32'(ex_alu_op[1]), 32'(onehot(alu_xor)));
      expect_eq("ex_rj_value[1]", ex_rj_value[1], rf_val(rj1));
      expect_eq("ex_rkd_value[1]", ex_rkd_value[1], rf_val(rk1));
      expect_eq("ex_pc[1]", ex_pc[1], pc_sent + 4);
    end

    step(r3(op5_add, 5'd3, 5'd2, 5'd4), r3(op5_add, 5'd5, 5'd4, 5'd6), 2'b11, 2'b01);
    step(r3(op5_add, 5'd3, 5'd2, 5'd4), r3(op5_add, 5'd4, 5'd5, 5'd6), 2'b11, 2'b01);
    step(ri16(op6_beq, 16'h8, 5'd1, 5'd2), r3(op5_or, 5'd5, 5'd7, 5'd6), 2'b11, 2'b01);
    step(ri12(op6_mem, op4_ld_w, 12'h0, 5'd1, 5'd2), r3(op5_or, 5'd5, 5'd7, 5'd6), 2'b11, 2'b01);
    step(r3(op5_add, 5'd3, 5'd2, 5'd9), ri12(op6_mem, op4_st_b, 12'h4, 5'd1, 5'd2), 2'b11, 2'b01);
    step(r3(op5_add, 5'd3, 5'd2, 5'd9), r3(op5_or, 5'd5, 5'd7, 5'd6), 2'b10, 2'b00);
    step(r3(op5_add, 5'd3, 5'd2, 5'd0), r3(op5_sub, 5'd0, 5'd0, 5'd6), 2'b11, 2'b11);

    // back-pressure, new word waits at the input
    held_imm = ex_imm[0];
    issue_ready = 1'b0;
    slot_inst[0] = ri12(op6_alu, op4_ori, 12'h0f0, 5'd1, 5'd2);
    slot_pc[0] = pc_next;
    repeat (4) begin
      #1;
      expect_eq("pop", 32'(pop), 32'h0);
      @(negedge clk);
      expect_eq("ex_imm[0]", ex_imm[0], held_imm);
      expect_eq("ex_valid", 32'(ex_valid), 32'h3);
    end
    issue_ready = 1'b1;
    @(negedge clk);
    expect_eq("ex_imm[0]", ex_imm[0], 32'h0000_00f0);

    issue_ready = 1'b0;
    flush = 1'b1;  // flush during a stall
    @(negedge clk);
    expect_eq("ex_valid", 32'(ex_valid), 32'h0);
    flush = 1'b0;

    step(r3(op5_and, 5'd3, 5'd2, 5'd7), r3(op5_nor, 5'd4, 5'd5, 5'd8), 2'b11, 2'b11);
    arst_n = 1'b0;
    #1;
    expect_eq("ex_valid", 32'(ex_valid), 32'h0);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/la_decode_pkg.sv
hdl/inst_decoder.sv
hdl/pair_check.sv
hdl/issue_reg.sv
hdl/decode_stage.sv
bench/decode_stage_checker.sv
bench/decode_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f build.f \
  --top-module decode_stage_tb \
  -o decode_stage_sim

./obj_dir/decode_stage_sim
